//--- logic/cr16Pkg.sv
package cr16Pkg;

	////////////////////
	// widths
	////////////////////

	// register and alu word
	localparam int dataWidth = 16;
	localparam int psrWidth = 5;
	localparam int regCount = 16;
	localparam int regIndexWidth = 4;

	// axi4-lite side
	localparam int axiAddrWidth = 8;
	localparam int axiDataWidth = 32;
	localparam logic [1:0] axiRespOkay = 2'b00;

	////////////////////
	// address map
	////////////////////

	// instruction word, write only
	localparam logic [axiAddrWidth-1:0] instrAddr = 8'h00;
	// status register, read only
	localparam logic [axiAddrWidth-1:0] psrAddr = 8'h04;
	// register n lives at regBase + 4n
	localparam logic [axiAddrWidth-1:0] regBase = 8'h40;

	// psr bit positions, CLFZN order
	localparam int flagC = 4;
	localparam int flagL = 3;
	localparam int flagF = 2;
	localparam int flagZ = 1;
	localparam int flagN = 0;

	////////////////////
	// encodings
	////////////////////

	// major opcode, instr[15:12]
	typedef enum logic [3:0] {
		RTYPE = 4'b0000,
		ANDI = 4'b0001,
		ORI = 4'b0010,
		XORI = 4'b0011,
		ADDI = 4'b0101,
		SHIFTI = 4'b1000,
		SUBI = 4'b1001,
		MOVI = 4'b1101,
		MULI = 4'b1110,
		LUI = 4'b1111
	} opcode_e;

	// function field of register forms, instr[7:4]
	typedef enum logic [3:0] {
		AND = 4'b0001,
		OR = 4'b0010,
		XOR = 4'b0011,
		NOT = 4'b0100,
		ADD = 4'b0101,
		ADDC = 4'b0111,
		LSH = 4'b1000,
		SUB = 4'b1001,
		SUBC = 4'b1010,
		SCOND = 4'b1011,
		ASHU = 4'b1100,
		MOV = 4'b1101,
		MUL = 4'b1110
	} funcCode_e;

	// internal alu operation
	typedef enum logic [3:0] {
		opAdd, opSub, opMul, opAnd, opOr, opXor,
		opNot, opMov, opLui, opLsh, opAshu, opScond
	} aluOp_e;

	// scond condition, held in the src field
	typedef enum logic [3:0] {
		EQ = 4'b0000, NE = 4'b0001, CS = 4'b0010, CC = 4'b0011,
		HI = 4'b0100, LS = 4'b0101, GT = 4'b0110, LE = 4'b0111,
		FS = 4'b1000, FC = 4'b1001, LT = 4'b1100, GE = 4'b1101,
		AL = 4'b1110
	} condCode_e;

endpackage

//--- logic/aluBus.sv
`timescale 1ns/1ps
interface aluBus;
	import cr16Pkg::*;

	// operands and decode fields from the execute stage
	logic [dataWidth-1:0] dst;
	logic [dataWidth-1:0] src;
	opcode_e oper;
	logic [3:0] func;
	logic [3:0] cond;
	logic [psrWidth-1:0] psrRead;

	// combinational alu answer, same cycle
	logic [dataWidth-1:0] result;
	logic [psrWidth-1:0] psrWrite;
	logic [psrWidth-1:0] psrWrEn;

	modport execute (
		output dst, src, oper, func, cond, psrRead,
		input result, psrWrite, psrWrEn
	);

	modport alu (
		input dst, src, oper, func, cond, psrRead,
		output result, psrWrite, psrWrEn
	);

endinterface

//--- logic/hostPort.sv
`timescale 1ns/1ps
interface hostPort;
	import cr16Pkg::*;

	// axi slave side, one-cycle pulses
	logic instrValid;
	logic [dataWidth-1:0] instr;
	logic regWrite;
	logic [regIndexWidth-1:0] regIndex;
	logic [dataWidth-1:0] regData;
	// combinational register read index
	logic [regIndexWidth-1:0] readIndex;

	// execute side
	logic execDone;
	logic [dataWidth-1:0] readData;
	logic [psrWidth-1:0] psr;

	modport slave (
		output instrValid, instr, regWrite, regIndex, regData, readIndex,
		input execDone, readData, psr
	);

	modport execute (
		input instrValid, instr, regWrite, regIndex, regData, readIndex,
		output execDone, readData, psr
	);

endinterface

//--- logic/aluController.sv
`timescale 1ns/1ps
module aluController (
	input cr16Pkg::opcode_e oper,
	input logic [3:0] func,
	output cr16Pkg::aluOp_e op,
	output logic [cr16Pkg::psrWidth-1:0] psrWrEn
);
	import cr16Pkg::*;

	// opcode and function field to alu operation
	always_comb begin
		op = opMov;
		case (oper)
			RTYPE: begin
				case (funcCode_e'(func))
					ADD, ADDC: op = opAdd;
					SUB, SUBC: op = opSub;
					MUL: op = opMul;
					AND: op = opAnd;
					OR: op = opOr;
					XOR: op = opXor;
					NOT: op = opNot;
					MOV: op = opMov;
					LSH: op = opLsh;
					ASHU: op = opAshu;
					SCOND: op = opScond;
					default: op = opMov;
				endcase
			end
			ADDI: op = opAdd;
			SUBI: op = opSub;
			MULI: op = opMul;
			ANDI: op = opAnd;
			ORI: op = opOr;
			XORI: op = opXor;
			MOVI: op = opMov;
			LUI: op = opLui;
			// bit 4 of the word picks arithmetic over logical
			SHIFTI: begin
				if (func[0])
					op = opAshu;
				else
					op = opLsh;
			end
			default: op = opMov;
		endcase
	end

	// which psr bits the operation is allowed to touch
	always_comb begin
		psrWrEn = '0;
		case (op)
			// add and subtract own all of CLFZN
			opAdd, opSub: psrWrEn = '1;
			// multiply and logic only Z and N
			opMul, opAnd, opOr, opXor, opNot: begin
				psrWrEn[flagZ] = 1'b1;
				psrWrEn[flagN] = 1'b1;
			end
			// moves, shifts and scond leave the psr alone
			default: psrWrEn = '0;
		endcase
	end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps
module alu (
	aluBus.alu bus
);
	import cr16Pkg::*;

	aluOp_e op;
	logic useCarry;
	logic isSub;
	logic carryIn;
	logic carryOut;
	logic [dataWidth-1:0] addend;
	logic [dataWidth-1:0] sum;
	logic [4:0] rightAmt;
	logic [dataWidth-1:0] leftShift;
	logic [dataWidth-1:0] logicRight;
	logic [dataWidth-1:0] arithRight;
	logic [dataWidth-1:0] shifted;
	logic condTrue;
	logic [dataWidth-1:0] result;
	logic [psrWidth-1:0] flags;

	aluController ctrl (
		.oper(bus.oper),
		.func(bus.func),
		.op(op),
		.psrWrEn(bus.psrWrEn)
	);

	////////////////////
	// add and subtract
	////////////////////

	// carry-in only counts for the register forms addc and subc
	assign useCarry = (bus.oper == RTYPE) && (bus.func == ADDC || bus.func == SUBC);
	assign isSub = (op == opSub);
	// sub is dst + ~src + 1
	assign addend = isSub ? ~bus.src : bus.src;
	// subc borrows when C is clear
	assign carryIn = useCarry ? bus.psrRead[flagC] : isSub;
	assign {carryOut, sum} = bus.dst + addend + carryIn;

	////////////////////
	// shifts
	////////////////////

	// amount is the signed low 5 bits of src
	assign rightAmt = -bus.src[4:0];
	assign leftShift = bus.dst << bus.src[3:0];
	assign logicRight = bus.dst >> rightAmt;
	// sign fill for ashu
	assign arithRight = $signed(bus.dst) >>> rightAmt;

	always_comb begin
		// negative amount goes right
		if (!bus.src[4])
			shifted = leftShift;
		else if (op == opAshu)
			shifted = arithRight;
		else
			shifted = logicRight;
	end

	// scond table against the incoming psr
	always_comb begin
		case (condCode_e'(bus.cond))
			EQ: condTrue = bus.psrRead[flagZ];
			NE: condTrue = !bus.psrRead[flagZ];
			CS: condTrue = bus.psrRead[flagC];
			CC: condTrue = !bus.psrRead[flagC];
			HI: condTrue = bus.psrRead[flagL];
			LS: condTrue = !bus.psrRead[flagL];
			GT: condTrue = bus.psrRead[flagN];
			LE: condTrue = !bus.psrRead[flagN];
			FS: condTrue = bus.psrRead[flagF];
			FC: condTrue = !bus.psrRead[flagF];
			LT: condTrue = !bus.psrRead[flagN] && !bus.psrRead[flagZ];
			GE: condTrue = bus.psrRead[flagN] || bus.psrRead[flagZ];
			AL: condTrue = 1'b1;
			// unassigned codes never hold
			default: condTrue = 1'b0;
		endcase
	end

	// result select
	always_comb begin
		case (op)
			opAdd, opSub: result = sum;
			// low half of the product
			opMul: result = bus.dst * bus.src;
			opAnd: result = bus.dst & bus.src;
			opOr: result = bus.dst | bus.src;
			opXor: result = bus.dst ^ bus.src;
			opNot: result = ~bus.dst;
			opMov: result = bus.src;
			// zero-extended immediate moves to the upper byte
			opLui: result = bus.src << (dataWidth / 2);
			opLsh, opAshu: result = shifted;
			opScond: result = dataWidth'(condTrue);
			default: result = bus.src;
		endcase
	end

	// flags, CLFZN, masked later by psrWrEn
	always_comb begin
		flags[flagC] = carryOut;
		// unsigned below, only for subtract
		flags[flagL] = isSub && (bus.dst < bus.src);
		// same operand signs, different result sign
		flags[flagF] = (bus.dst[dataWidth-1] == addend[dataWidth-1])
			&& (sum[dataWidth-1] != bus.dst[dataWidth-1]);
		flags[flagZ] = (result == '0);
		flags[flagN] = result[dataWidth-1];
	end

	assign bus.result = result;
	assign bus.psrWrite = flags;

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps
module registerFile (
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input logic [cr16Pkg::regIndexWidth-1:0] writeIndex,
	input logic [cr16Pkg::dataWidth-1:0] writeData,
	input logic [cr16Pkg::regIndexWidth-1:0] readIndexA,
	output logic [cr16Pkg::dataWidth-1:0] readDataA,
	input logic [cr16Pkg::regIndexWidth-1:0] readIndexB,
	output logic [cr16Pkg::dataWidth-1:0] readDataB,
	input logic [cr16Pkg::regIndexWidth-1:0] readIndexHost,
	output logic [cr16Pkg::dataWidth-1:0] readDataHost
);
	import cr16Pkg::*;

	logic [dataWidth-1:0] regs [regCount];

	// single write port, all registers cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeIndex] <= writeData;
		end
	end

	// dst operand
	assign readDataA = regs[readIndexA];
	// src operand
	assign readDataB = regs[readIndexB];
	// host readback
	assign readDataHost = regs[readIndexHost];

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps
module executeStage (
	input logic clk,
	input logic reset,
	hostPort.execute host
);
	import cr16Pkg::*;

	logic [dataWidth-1:0] instrReg;
	logic busy;
	logic [psrWidth-1:0] psr;
	opcode_e oper;
	logic [7:0] imm;
	logic [dataWidth-1:0] srcReg;
	logic [dataWidth-1:0] srcOperand;
	logic writesResult;
	logic regWe;
	logic [regIndexWidth-1:0] regWi;
	logic [dataWidth-1:0] regWd;

	aluBus aluIf ();

	alu aluUnit (
		.bus(aluIf.alu)
	);

	// dst from instr[11:8], src from instr[3:0]
	registerFile regs (
		.clk(clk),
		.reset(reset),
		.writeEnable(regWe),
		.writeIndex(regWi),
		.writeData(regWd),
		.readIndexA(instrReg[11:8]),
		.readDataA(aluIf.dst),
		.readIndexB(instrReg[3:0]),
		.readDataB(srcReg),
		.readIndexHost(host.readIndex),
		.readDataHost(host.readData)
	);

	// instruction latched on the instrValid edge
	always_ff @(posedge clk) begin
		if (host.instrValid)
			instrReg <= host.instr;
	end

	// busy marks the writeback cycle, one after the latch
	always_ff @(posedge clk) begin
		if (reset)
			busy <= 1'b0;
		else
			busy <= host.instrValid;
	end

	assign oper = opcode_e'(instrReg[15:12]);
	assign imm = instrReg[7:0];

	// source operand, register or immediate
	always_comb begin
		case (oper)
			RTYPE: srcOperand = srcReg;
			ADDI, SUBI, MULI: srcOperand = {{(dataWidth-8){imm[7]}}, imm};
			// signed 4-bit shift amount
			SHIFTI: srcOperand = {{(dataWidth-4){imm[3]}}, imm[3:0]};
			default: srcOperand = {{(dataWidth-8){1'b0}}, imm};
		endcase
	end

	// only defined instructions write back
	always_comb begin
		case (oper)
			RTYPE: begin
				case (funcCode_e'(instrReg[7:4]))
					ADD, ADDC, SUB, SUBC, MUL, AND, OR, XOR, NOT,
					MOV, LSH, ASHU, SCOND: writesResult = 1'b1;
					default: writesResult = 1'b0;
				endcase
			end
			ADDI, SUBI, MULI, ANDI, ORI, XORI, MOVI, LUI, SHIFTI: writesResult = 1'b1;
			default: writesResult = 1'b0;
		endcase
	end

	assign aluIf.oper = oper;
	assign aluIf.func = instrReg[7:4];
	assign aluIf.cond = instrReg[3:0];
	assign aluIf.src = srcOperand;
	assign aluIf.psrRead = psr;

	// writeback owns the port, host writes pass through otherwise
	assign regWe = busy ? writesResult : host.regWrite;
	assign regWi = busy ? instrReg[11:8] : host.regIndex;
	assign regWd = busy ? aluIf.result : host.regData;

	// merge only the enabled flag bits
	always_ff @(posedge clk) begin
		if (reset)
			psr <= '0;
		else if (busy)
			psr <= (psr & ~aluIf.psrWrEn) | (aluIf.psrWrite & aluIf.psrWrEn);
	end

	assign host.execDone = busy;
	assign host.psr = psr;

endmodule

//--- logic/axiLiteSlave.sv
`timescale 1ns/1ps
module axiLiteSlave (
	input logic clk,
	input logic reset,
	input logic [cr16Pkg::axiAddrWidth-1:0] awAddr,
	input logic awValid,
	output logic awReady,
	input logic [cr16Pkg::axiDataWidth-1:0] wData,
	input logic [cr16Pkg::axiDataWidth/8-1:0] wStrb,
	input logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input logic bReady,
	input logic [cr16Pkg::axiAddrWidth-1:0] arAddr,
	input logic arValid,
	output logic arReady,
	output logic [cr16Pkg::axiDataWidth-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input logic rReady,
	hostPort.slave host
);
	import cr16Pkg::*;

	typedef enum logic [1:0] {idle, execWait, respond} writeState_e;

	writeState_e writeState;
	logic writeAccept;
	logic readAccept;
	logic awInRegs;
	logic arInRegs;
	logic [axiDataWidth-1:0] readWord;

	////////////////////
	// write channels
	////////////////////

	// address and data taken together, only when idle
	assign awReady = (writeState == idle);
	assign wReady = (writeState == idle);
	assign writeAccept = awValid && wValid && awReady && wReady;
	assign bValid = (writeState == respond);
	assign bResp = axiRespOkay;
	// register window is regBase + 4n, n in 0..15
	assign awInRegs = awAddr[axiAddrWidth-1:regIndexWidth+2]
		== regBase[axiAddrWidth-1:regIndexWidth+2];

	always_ff @(posedge clk) begin
		if (reset) begin
			writeState <= idle;
			host.instrValid <= 1'b0;
			host.regWrite <= 1'b0;
		end else begin
			host.instrValid <= 1'b0;
			host.regWrite <= 1'b0;
			case (writeState)
				idle: begin
					if (writeAccept && awAddr == instrAddr) begin
						// response waits for the writeback
						host.instrValid <= 1'b1;
						writeState <= execWait;
					end else if (writeAccept) begin
						// unmapped and psr writes are dropped
						host.regWrite <= awInRegs;
						writeState <= respond;
					end
				end
				execWait: begin
					if (host.execDone)
						writeState <= respond;
				end
				respond: begin
					if (bReady)
						writeState <= idle;
				end
				default: writeState <= idle;
			endcase
		end
	end

	// full-word writes, wStrb is not looked at
	always_ff @(posedge clk) begin
		if (writeAccept) begin
			host.instr <= wData[dataWidth-1:0];
			host.regIndex <= awAddr[regIndexWidth+1:2];
			host.regData <= wData[dataWidth-1:0];
		end
	end

	////////////////////
	// read channels
	////////////////////

	assign arReady = !rValid;
	assign readAccept = arValid && arReady;
	assign rResp = axiRespOkay;
	assign host.readIndex = arAddr[regIndexWidth+1:2];
	assign arInRegs = arAddr[axiAddrWidth-1:regIndexWidth+2]
		== regBase[axiAddrWidth-1:regIndexWidth+2];

	// register, psr, or zero for anything else
	always_comb begin
		if (arInRegs)
			readWord = axiDataWidth'(host.readData);
		else if (arAddr == psrAddr)
			readWord = axiDataWidth'(host.psr);
		else
			readWord = '0;
	end

	// rValid holds until rReady
	always_ff @(posedge clk) begin
		if (reset)
			rValid <= 1'b0;
		else if (readAccept)
			rValid <= 1'b1;
		else if (rReady)
			rValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (readAccept)
			rData <= readWord;
	end

endmodule

//--- logic/cr16Top.sv
`timescale 1ns/1ps
module cr16Top (
	input logic clk,
	input logic reset,
	input logic [cr16Pkg::axiAddrWidth-1:0] awAddr,
	input logic awValid,
	output logic awReady,
	input logic [cr16Pkg::axiDataWidth-1:0] wData,
	input logic [cr16Pkg::axiDataWidth/8-1:0] wStrb,
	input logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input logic bReady,
	input logic [cr16Pkg::axiAddrWidth-1:0] arAddr,
	input logic arValid,
	output logic arReady,
	output logic [cr16Pkg::axiDataWidth-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input logic rReady
);

	// one host link between bus slave and core
	hostPort host ();

	axiLiteSlave axiSlave (
		.clk(clk),
		.reset(reset),
		.awAddr(awAddr),
		.awValid(awValid),
		.awReady(awReady),
		.wData(wData),
		.wStrb(wStrb),
		.wValid(wValid),
		.wReady(wReady),
		.bResp(bResp),
		.bValid(bValid),
		.bReady(bReady),
		.arAddr(arAddr),
		.arValid(arValid),
		.arReady(arReady),
		.rData(rData),
		.rResp(rResp),
		.rValid(rValid),
		.rReady(rReady),
		.host(host.slave)
	);

	executeStage execUnit (
		.clk(clk),
		.reset(reset),
		.host(host.execute)
	);

endmodule

//--- tb/cr16Checker.sv
`timescale 1ns/1ps
module cr16Checker (
	input logic clk,
	input logic reset,
	input logic [cr16Pkg::axiAddrWidth-1:0] awAddr,
	input logic awValid,
	input logic awReady,
	input logic wValid,
	input logic wReady,
	input logic bValid,
	input logic bReady,
	input logic arValid,
	input logic arReady,
	input logic [cr16Pkg::axiDataWidth-1:0] rData,
	input logic rValid,
	input logic rReady
);
	import cr16Pkg::*;

	// bumped by every failing property, read back by the testbench
	int failCount = 0;
	logic instrAccept;

	// write handshake aimed at the instruction word
	assign instrAccept = awValid && wValid && awReady && wReady && (awAddr == instrAddr);

	////////////////////
	// handshake holds
	////////////////////

	bHeld: assert property (@(posedge clk) disable iff (reset)
		bValid && !bReady |=> bValid)
	else begin
		$error("write response dropped before bReady");
		failCount++;
	end

	// data must not move while parked
	rHeld: assert property (@(posedge clk) disable iff (reset)
		rValid && !rReady |=> rValid && $stable(rData))
	else begin
		$error("read data dropped or changed before rReady");
		failCount++;
	end

	////////////////////
	// back-pressure
	////////////////////

	noWriteDuringResp: assert property (@(posedge clk) disable iff (reset)
		bValid |-> !awReady)
	else begin
		$error("awReady high while a write response waits");
		failCount++;
	end

	noReadDuringResp: assert property (@(posedge clk) disable iff (reset)
		rValid |-> !arReady)
	else begin
		$error("arReady high while read data waits");
		failCount++;
	end

	// both response channels quiet as reset lets go
	quietAfterReset: assert property (@(posedge clk)
		$fell(reset) |-> !bValid && !rValid)
	else begin
		$error("response valid high right after reset");
		failCount++;
	end

	// latch, writeback, then the response
	instrResponse: assert property (@(posedge clk) disable iff (reset)
		instrAccept |-> ##1 !bValid ##1 !bValid ##1 bValid)
	else begin
		$error("instruction response not exactly three cycles after accept");
		failCount++;
	end

endmodule

//--- tb/cr16Tb.sv
`timescale 1ns/1ps
module cr16Tb;
	import cr16Pkg::*;

	localparam int clkPeriod = 100;
	// 95 instructions, each a write and two reads, plus plain register traffic
	localparam int execCount = 95;
	localparam int hostCount = 60;
	localparam int opCount = 3 * execCount + hostCount;

	logic clk;
	logic reset;
	logic [axiAddrWidth-1:0] awAddr;
	logic awValid;
	logic awReady;
	logic [axiDataWidth-1:0] wData;
	logic [axiDataWidth/8-1:0] wStrb;
	logic wValid;
	logic wReady;
	logic [1:0] bResp;
	logic bValid;
	logic bReady;
	logic [axiAddrWidth-1:0] arAddr;
	logic arValid;
	logic arReady;
	logic [axiDataWidth-1:0] rData;
	logic [1:0] rResp;
	logic rValid;
	logic rReady;

	logic [15:0] lfsr;
	logic [15:0] refRegs [16];
	logic [4:0] refPsr;
	logic [15:0] presetA [4];
	logic [15:0] presetB [4];
	logic [31:0] wideA;
	logic [31:0] wideB;
	logic [31:0] lo;
	logic [31:0] hi;
	int errorCount;
	int totalErrors;

	cr16Top uut (.*);

	bind cr16Top cr16Checker protocolCheck (
		.clk(clk),
		.reset(reset),
		.awAddr(awAddr),
		.awValid(awValid),
		.awReady(awReady),
		.wValid(wValid),
		.wReady(wReady),
		.bValid(bValid),
		.bReady(bReady),
		.arValid(arValid),
		.arReady(arReady),
		.rData(rData),
		.rValid(rValid),
		.rReady(rReady)
	);

	always #(clkPeriod / 2) clk = ~clk;

	////////////////////
	// helpers
	////////////////////

	// galois lfsr, one step per bit taken
	function automatic logic [15:0] randomBits(input int count);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return value;
	endfunction

	function automatic logic [7:0] regAddr(input logic [3:0] idx);
		return regBase + {2'b00, idx, 2'b00};
	endfunction

	function automatic logic [15:0] rForm(input logic [3:0] func, input logic [3:0] dst,
		input logic [3:0] src);
		return {RTYPE, dst, func, src};
	endfunction

	function automatic logic [15:0] iForm(input logic [3:0] opc, input logic [3:0] dst,
		input logic [7:0] imm);
		return {opc, dst, imm};
	endfunction

	// cr16 condition table over CLFZN
	function automatic logic condHolds(input logic [3:0] code, input logic [4:0] p);
		case (code)
			EQ: return p[flagZ];
			NE: return !p[flagZ];
			CS: return p[flagC];
			CC: return !p[flagC];
			HI: return p[flagL];
			LS: return !p[flagL];
			GT: return p[flagN];
			LE: return !p[flagN];
			FS: return p[flagF];
			FC: return !p[flagF];
			LT: return !p[flagN] && !p[flagZ];
			GE: return p[flagN] || p[flagZ];
			AL: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// reference model, one instruction
	task automatic modelStep(input logic [15:0] instr);
		logic [3:0] opc;
		logic [3:0] kind;
		logic [7:0] imm;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] addend;
		logic [15:0] res;
		logic [16:0] full;
		logic [4:0] flags;
		logic [4:0] mask;
		logic isSub;
		logic carryIn;
		int amount;
		opc = instr[15:12];
		imm = instr[7:0];
		a = refRegs[instr[11:8]];
		// sign-extended for arithmetic, signed nibble for shifts, zero-extended else
		case (opc)
			RTYPE: b = refRegs[instr[3:0]];
			ADDI, SUBI, MULI: b = {{8{imm[7]}}, imm};
			SHIFTI: b = {{12{imm[3]}}, imm[3:0]};
			default: b = {8'h00, imm};
		endcase
		// immediate forms act like their register twins
		case (opc)
			RTYPE: kind = instr[7:4];
			ADDI: kind = ADD;
			SUBI: kind = SUB;
			MULI: kind = MUL;
			ANDI: kind = AND;
			ORI: kind = OR;
			XORI: kind = XOR;
			SHIFTI: kind = imm[4] ? ASHU : LSH;
			default: kind = MOV;
		endcase
		isSub = (kind == SUB) || (kind == SUBC);
		carryIn = (kind == ADDC || kind == SUBC) ? refPsr[flagC] : isSub;
		addend = isSub ? ~b : b;
		full = {1'b0, a} + {1'b0, addend} + {16'h0000, carryIn};
		amount = int'($signed(b[4:0]));
		case (kind)
			ADD, ADDC, SUB, SUBC: res = full[15:0];
			MUL: res = a * b;
			AND: res = a & b;
			OR: res = a | b;
			XOR: res = a ^ b;
			NOT: res = ~a;
			LSH, ASHU: begin
				if (amount >= 0)
					res = a << amount;
				else if (kind == ASHU)
					res = $signed(a) >>> -amount;
				else
					res = a >> -amount;
			end
			SCOND: res = {15'h0000, condHolds(instr[3:0], refPsr)};
			default: res = b;
		endcase
		// lui puts the byte on top
		if (opc == LUI)
			res = {imm, 8'h00};
		case (kind)
			ADD, ADDC, SUB, SUBC: mask = 5'b11111;
			MUL, AND, OR, XOR, NOT: mask = 5'b00011;
			default: mask = 5'b00000;
		endcase
		flags[flagC] = full[16];
		flags[flagL] = isSub && (a < b);
		flags[flagF] = (a[15] == addend[15]) && (full[15] != a[15]);
		flags[flagZ] = (res == 16'h0000);
		flags[flagN] = res[15];
		refPsr = (refPsr & ~mask) | (flags & mask);
		refRegs[instr[11:8]] = res;
	endtask

	task automatic expectEqual(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	////////////////////
	// axi4-lite access
	////////////////////

	task automatic writeAxi(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		awAddr = addr;
		wData = data;
		awValid = 1'b1;
		wValid = 1'b1;
		bReady = 1'b1;
		do @(posedge clk); while (!(awReady && wReady));
		#1;
		awValid = 1'b0;
		wValid = 1'b0;
		// instruction writes answer only after writeback
		do @(posedge clk); while (!bValid);
		// every response is OKAY
		expectEqual("write response", 32'h0000_0000, {30'h0, bResp});
	endtask

	// rReady held low for holdCycles once the read is accepted
	task automatic readAxi(input logic [7:0] addr, input int holdCycles,
		output logic [31:0] data);
		@(posedge clk);
		#1;
		arAddr = addr;
		arValid = 1'b1;
		rReady = (holdCycles == 0);
		do @(posedge clk); while (!arReady);
		#1;
		arValid = 1'b0;
		repeat (holdCycles) @(posedge clk);
		#1;
		rReady = 1'b1;
		do @(posedge clk); while (!rValid);
		data = rData;
		expectEqual("read response", 32'h0000_0000, {30'h0, rResp});
	endtask

	task automatic writeReg(input logic [3:0] idx, input logic [15:0] value);
		writeAxi(regAddr(idx), {16'h0000, value});
		refRegs[idx] = value;
	endtask

	task automatic readBack(input logic [3:0] idx, input string name);
		logic [31:0] data;
		readAxi(regAddr(idx), 0, data);
		expectEqual(name, {16'h0000, refRegs[idx]}, data);
	endtask

	task automatic checkPsr(input string name);
		logic [31:0] data;
		readAxi(psrAddr, 0, data);
		expectEqual(name, {27'h0000000, refPsr}, data);
	endtask

	task automatic execute(input logic [15:0] instr, input string name);
		writeAxi(instrAddr, {16'h0000, instr});
		modelStep(instr);
		readBack(instr[11:8], {name, " result"});
		checkPsr({name, " psr"});
	endtask

	// second instruction offered while the first response is parked
	task automatic heldPair(input logic [15:0] first, input logic [15:0] second,
		input int holdCycles);
		@(posedge clk);
		#1;
		awAddr = instrAddr;
		wData = {16'h0000, first};
		awValid = 1'b1;
		wValid = 1'b1;
		bReady = 1'b0;
		do @(posedge clk); while (!(awReady && wReady));
		#1;
		wData = {16'h0000, second};
		do @(posedge clk); while (!bValid);
		repeat (holdCycles) begin
			@(posedge clk);
			assert (!awReady && bValid)
			else begin
				$display("second instruction accepted while the first response was pending");
				errorCount++;
			end
		end
		#1;
		bReady = 1'b1;
		do @(posedge clk); while (!(awReady && wReady));
		#1;
		awValid = 1'b0;
		wValid = 1'b0;
		do @(posedge clk); while (!bValid);
	endtask

	////////////////////
	// watchdog
	////////////////////

	initial begin
		#(clkPeriod * (opCount * 10 + 100));
		$display("watchdog expired before all tests finished");
		$display("Verification failed");
		$finish;
	end

	////////////////////
	// test sequence
	////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wStrb = 4'hf;
		wValid = 1'b0;
		bReady = 1'b1;
		arAddr = '0;
		arValid = 1'b0;
		rReady = 1'b1;
		lfsr = 16'd16193;
		refPsr = '0;
		errorCount = 0;
		presetA = '{16'h0005, 16'h0003, 16'h8000, 16'h7fff};
		presetB = '{16'h0005, 16'h0009, 16'h0001, 16'hffff};
		for (int i = 0; i < 16; i++) begin
			refRegs[i] = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// register round trip, psr clear out of reset
		checkPsr("psr after reset");
		for (int i = 0; i < 16; i++) begin
			writeReg(4'(i), randomBits(16));
		end
		for (int i = 0; i < 16; i++) begin
			readBack(4'(i), "register round trip");
		end

		// add and subtract with flags
		execute(rForm(ADD, 4'd1, 4'd2), "add");
		execute(rForm(SUB, 4'd3, 4'd4), "sub");
		execute(iForm(ADDI, 4'd5, 8'(randomBits(8))), "addi");
		execute(iForm(SUBI, 4'd6, 8'(randomBits(8))), "subi");
		// 32-bit sum, low halves forced to carry
		wideA = {randomBits(16), 16'hf000 | randomBits(16)};
		wideB = {randomBits(16), 16'h8000 | randomBits(16)};
		writeReg(4'd7, wideA[15:0]);
		writeReg(4'd8, wideA[31:16]);
		writeReg(4'd9, wideB[15:0]);
		writeReg(4'd10, wideB[31:16]);
		execute(rForm(ADD, 4'd7, 4'd9), "add low");
		execute(rForm(ADDC, 4'd8, 4'd10), "addc high");
		readAxi(regAddr(4'd7), 0, lo);
		readAxi(regAddr(4'd8), 0, hi);
		expectEqual("wide sum", wideA + wideB, {hi[15:0], lo[15:0]});

		// multiply, logic and moves
		execute(rForm(MUL, 4'd1, 4'd3), "mul");
		execute(iForm(MULI, 4'd2, 8'(randomBits(8))), "muli");
		execute(rForm(AND, 4'd4, 4'd5), "and");
		execute(iForm(ANDI, 4'd4, 8'(randomBits(8))), "andi");
		execute(rForm(OR, 4'd6, 4'd7), "or");
		execute(iForm(ORI, 4'd6, 8'(randomBits(8))), "ori");
		execute(rForm(XOR, 4'd9, 4'd10), "xor");
		execute(iForm(XORI, 4'd9, 8'(randomBits(8))), "xori");
		execute(rForm(NOT, 4'd11, 4'd0), "not");
		execute(rForm(MOV, 4'd12, 4'd1), "mov");
		execute(iForm(MOVI, 4'd13, 8'(randomBits(8))), "movi");
		execute(iForm(LUI, 4'd14, 8'(randomBits(8))), "lui");

		// shifts, +3 and -5 as amounts
		writeReg(4'd1, 16'h0003);
		writeReg(4'd2, 16'hfffb);
		writeReg(4'd3, 16'h9000 | randomBits(16));
		writeReg(4'd8, 16'h8000 | randomBits(16));
		execute(rForm(LSH, 4'd4, 4'd1), "lsh left");
		execute(rForm(LSH, 4'd5, 4'd2), "lsh right");
		execute(rForm(ASHU, 4'd3, 4'd2), "ashu right");
		execute(rForm(ASHU, 4'd6, 4'd1), "ashu left");
		execute(iForm(SHIFTI, 4'd7, 8'h03), "shifti left");
		execute(iForm(SHIFTI, 4'd8, 8'h1d), "shifti arith right");
		execute(iForm(SHIFTI, 4'd9, 8'h0a), "shifti logic right");

		// scond over every code after each preset
		for (int p = 0; p < 4; p++) begin
			writeReg(4'd11, presetA[p]);
			writeReg(4'd12, presetB[p]);
			execute(rForm(SUB, 4'd11, 4'd12), "scond preset");
			for (int c = 0; c < 16; c++) begin
				execute(rForm(SCOND, 4'd13, 4'(c)), "scond");
			end
		end

		// back-pressure on both response channels
		heldPair(rForm(ADD, 4'd1, 4'd2), rForm(SUB, 4'd3, 4'd1), 5);
		modelStep(rForm(ADD, 4'd1, 4'd2));
		modelStep(rForm(SUB, 4'd3, 4'd1));
		readBack(4'd1, "held add");
		readAxi(regAddr(4'd3), 4, lo);
		expectEqual("held sub", {16'h0000, refRegs[3]}, lo);
		checkPsr("held psr");

		totalErrors = errorCount + uut.protocolCheck.failCount;
		$display("checks done: %0d value errors, %0d protocol errors",
			errorCount, uut.protocolCheck.failCount);
		if (totalErrors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- flist.f
logic/cr16Pkg.sv
logic/aluBus.sv
logic/hostPort.sv
logic/aluController.sv
logic/alu.sv
logic/registerFile.sv
logic/executeStage.sv
logic/axiLiteSlave.sv
logic/cr16Top.sv
tb/cr16Checker.sv
tb/cr16Tb.sv

//--- Bender.yml
package:
  name: cr16

sources:
  - logic/cr16Pkg.sv
  - logic/aluBus.sv
  - logic/hostPort.sv
  - logic/aluController.sv
  - logic/alu.sv
  - logic/registerFile.sv
  - logic/executeStage.sv
  - logic/axiLiteSlave.sv
  - logic/cr16Top.sv
  - target: test
    files:
      - tb/cr16Checker.sv
      - tb/cr16Tb.sv
